// File: source/fetch_params.svh
`ifndef FETCH_PARAMS_SVH
`define FETCH_PARAMS_SVH

// ***************************************************************************
// fetch front end sizing.
// ***************************************************************************

// address width of the core.
`define FETCH_ADDR_W 64

// instruction cache geometry.
`define ICACHE_SETS       64
`define ICACHE_WAYS       4
`define ICACHE_LINE_BYTES 16

// first fetch address out of reset.
`define FETCH_RESET_PC 64'h8000_0000

`endif

// File: source/fetch_pkg.sv
`include "fetch_params.svh"

package fetch_pkg;

	// address split: | tag | index | offset |.
	localparam int OFFSET_W = $clog2(`ICACHE_LINE_BYTES);
	localparam int INDEX_W  = $clog2(`ICACHE_SETS);
	localparam int TAG_W    = `FETCH_ADDR_W - INDEX_W - OFFSET_W;
	localparam int LINE_W   = `ICACHE_LINE_BYTES * 8;

	// byte address.
	typedef logic [`FETCH_ADDR_W-1:0] addr_t;

	typedef logic [31:0] inst_t; // one instruction word.

	// cache line, word 0 sits in the low bits.
	typedef logic [LINE_W-1:0] line_t;

	typedef logic [INDEX_W-1:0] index_t; // addr[9:4].
	typedef logic [TAG_W-1:0]   tag_t;   // addr[63:10].

	// one-hot way select, all zero means no way.
	typedef logic [`ICACHE_WAYS-1:0] way_t;

endpackage

// File: source/fetch_stage_if.sv
interface fetch_stage_if;

	// lookup in flight.
	fetch_pkg::addr_t addr;
	logic             valid;

	// lookup result.
	logic             hit;
	fetch_pkg::way_t  way;  // hit way, or victim on a miss.
	fetch_pkg::line_t line; // line read from backing memory.

	// pipeline control.
	logic advance; // lookup moves on this cycle.
	logic squash;  // redirect, drop this lookup.

	modport tag (
		output addr,
		output valid,
		output hit,
		output way,
		output line,
		output advance,
		output squash
	);

	modport data (
		input addr,
		input valid,
		input hit,
		input way,
		input line,
		input advance,
		input squash
	);

endinterface

// File: source/pc_gen.sv
`include "fetch_params.svh"

module pc_gen (
	input  logic             clk,
	input  logic             rst,
	input  logic             stall,
	input  logic             redirect,
	input  fetch_pkg::addr_t redirect_pc,
	output fetch_pkg::addr_t pc,
	output logic             pc_valid,
	output logic             accept
);

	// the one place where the pipeline decides to move.
	assign accept = !stall || redirect; // redirect beats stall.

	// ***********************************************************************
	// fetch address register.
	// ***********************************************************************

	always_ff @(posedge clk) begin
		if (rst) begin
			pc       <= `FETCH_RESET_PC;
			pc_valid <= 1'b0;
		end else begin
			pc_valid <= 1'b1; // low for one cycle only.
			if (redirect) begin
				pc <= redirect_pc;
			end else if (accept && pc_valid) begin
				pc <= pc + 'd4; // next word.
			end
		end
	end

endmodule

// File: source/icache_tag_stage.sv
`include "fetch_params.svh"

module icache_tag_stage (
	input  logic             clk,
	input  logic             rst,
	input  fetch_pkg::addr_t pc,
	input  logic             pc_valid,
	input  logic             accept,
	input  logic             redirect,
	output fetch_pkg::addr_t mem_addr,
	input  fetch_pkg::line_t mem_line,
	fetch_stage_if.tag       st
);

	// tag and valid state, one array per way.
	fetch_pkg::tag_t         tag_q [`ICACHE_WAYS][`ICACHE_SETS];
	logic [`ICACHE_SETS-1:0] vld_q [`ICACHE_WAYS];
	fetch_pkg::way_t         repl_q; // victim pointer, one-hot.

	fetch_pkg::index_t index;
	fetch_pkg::tag_t   tag;
	fetch_pkg::way_t   hit_way;
	logic              hit;
	logic              refill;

	assign index = pc[fetch_pkg::OFFSET_W +: fetch_pkg::INDEX_W];
	assign tag   = pc[`FETCH_ADDR_W-1 -: fetch_pkg::TAG_W];

	// ***********************************************************************
	// lookup.
	// ***********************************************************************

	always_comb begin
		for (int w = 0; w < `ICACHE_WAYS; w++) begin
			hit_way[w] = vld_q[w][index] && (tag_q[w][index] == tag);
		end
	end

	assign hit = |hit_way;

	// miss fills the pointed way in this same cycle.
	assign refill = pc_valid && accept && !redirect && !hit;

	// line-aligned request to backing memory.
	always_comb begin
		mem_addr = pc;
		mem_addr[fetch_pkg::OFFSET_W-1:0] = '0;
	end

	// ***********************************************************************
	// refill and replacement.
	// ***********************************************************************

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int w = 0; w < `ICACHE_WAYS; w++) begin
				vld_q[w] <= '0;
			end
			repl_q <= fetch_pkg::way_t'(1); // start at way 0.
		end else if (refill) begin
			for (int w = 0; w < `ICACHE_WAYS; w++) begin
				if (repl_q[w]) begin
					vld_q[w][index] <= 1'b1;
				end
			end
			// rotate once per refill.
			repl_q <= {repl_q[`ICACHE_WAYS-2:0], repl_q[`ICACHE_WAYS-1]};
		end
	end

	always_ff @(posedge clk) begin
		if (refill) begin
			for (int w = 0; w < `ICACHE_WAYS; w++) begin
				if (repl_q[w]) begin
					tag_q[w][index] <= tag;
				end
			end
		end
	end

	// ***********************************************************************
	// to data stage.
	// ***********************************************************************

	assign st.addr    = pc;
	assign st.valid   = pc_valid;
	assign st.hit     = hit;
	assign st.way     = hit ? hit_way : repl_q; // victim on a miss.
	assign st.line    = mem_line;
	assign st.advance = accept;
	assign st.squash  = redirect;

endmodule

// File: source/way_sram.sv
`include "fetch_params.svh"

module way_sram (
	input  logic              clk,
	input  logic              en,
	input  logic              we,
	input  fetch_pkg::index_t index,
	input  fetch_pkg::line_t  wdata,
	output fetch_pkg::line_t  rdata
);

	fetch_pkg::line_t mem [`ICACHE_SETS];

	// single port, registered read.
	// rdata keeps its value while disabled.
	always_ff @(posedge clk) begin
		if (en) begin
			if (we) begin
				mem[index] <= wdata;
				rdata      <= wdata; // write-through on the read port.
			end else begin
				rdata <= mem[index];
			end
		end
	end

endmodule

// File: source/icache_data_stage.sv
`include "fetch_params.svh"

module icache_data_stage (
	input  logic             clk,
	input  logic             rst,
	fetch_stage_if.data      st,
	output fetch_pkg::inst_t inst,
	output fetch_pkg::addr_t inst_pc,
	output logic             inst_valid,
	output logic             inst_hit
);

	localparam int INST_W = $bits(fetch_pkg::inst_t);

	logic              go;
	fetch_pkg::index_t index;
	fetch_pkg::line_t  rdata [`ICACHE_WAYS];

	// output stage registers.
	fetch_pkg::way_t  way_q;
	fetch_pkg::line_t line_q;
	fetch_pkg::addr_t addr_q;
	logic             valid_q;
	logic             hit_q;

	fetch_pkg::line_t dout;

	assign go    = st.valid && st.advance && !st.squash;
	assign index = st.addr[fetch_pkg::OFFSET_W +: fetch_pkg::INDEX_W];

	// ***********************************************************************
	// way memories, only the selected way is enabled.
	// ***********************************************************************

	for (genvar w = 0; w < `ICACHE_WAYS; w++) begin : g_way
		way_sram u_way_sram (
			.clk   (clk),
			.en    (go && st.way[w]),
			.we    (!st.hit), // refill on a miss.
			.index (index),
			.wdata (st.line),
			.rdata (rdata[w])
		);
	end

	// ***********************************************************************
	// output registers.
	// ***********************************************************************

	always_ff @(posedge clk) begin
		if (rst) begin
			way_q   <= '0;
			valid_q <= 1'b0;
			hit_q   <= 1'b0;
		end else if (st.squash) begin
			valid_q <= 1'b0; // drop the redirected lookup.
			hit_q   <= 1'b0;
		end else if (st.advance) begin
			way_q   <= st.way;
			valid_q <= st.valid;
			hit_q   <= st.valid && st.hit;
		end
	end

	always_ff @(posedge clk) begin
		if (st.advance && !st.squash) begin
			line_q <= st.line;
			addr_q <= st.addr;
		end
	end

	// way data on a hit, memory line on a miss.
	always_comb begin
		dout = line_q;
		if (hit_q) begin
			for (int w = 0; w < `ICACHE_WAYS; w++) begin
				if (way_q[w]) begin
					dout = rdata[w];
				end
			end
		end
	end

	assign inst       = dout[addr_q[fetch_pkg::OFFSET_W-1:2] * INST_W +: INST_W];
	assign inst_pc    = addr_q;
	assign inst_valid = valid_q;
	assign inst_hit   = hit_q;

endmodule

// File: source/fetch_unit.sv
module fetch_unit (
	input  logic             clk,
	input  logic             rst,

	// downstream control.
	input  logic             stall,
	input  logic             redirect,
	input  fetch_pkg::addr_t redirect_pc,

	// backing memory, read in the lookup cycle.
	output fetch_pkg::addr_t mem_addr,
	input  fetch_pkg::line_t mem_line,

	// fetched instruction.
	output fetch_pkg::inst_t inst,
	output fetch_pkg::addr_t inst_pc,
	output logic             inst_valid,
	output logic             inst_hit
);

	fetch_pkg::addr_t pc;
	logic             pc_valid;
	logic             accept;

	fetch_stage_if st_if ();

	// ***********************************************************************
	// pc stage.
	// ***********************************************************************

	pc_gen u_pc_gen (
		.clk         (clk),
		.rst         (rst),
		.stall       (stall),
		.redirect    (redirect),
		.redirect_pc (redirect_pc),
		.pc          (pc),
		.pc_valid    (pc_valid),
		.accept      (accept)
	);

	// ***********************************************************************
	// tag lookup and refill.
	// ***********************************************************************

	icache_tag_stage u_icache_tag_stage (
		.clk      (clk),
		.rst      (rst),
		.pc       (pc),
		.pc_valid (pc_valid),
		.accept   (accept),
		.redirect (redirect),
		.mem_addr (mem_addr),
		.mem_line (mem_line),
		.st       (st_if.tag)
	);

	// ***********************************************************************
	// data ways and word select.
	// ***********************************************************************

	icache_data_stage u_icache_data_stage (
		.clk        (clk),
		.rst        (rst),
		.st         (st_if.data),
		.inst       (inst),
		.inst_pc    (inst_pc),
		.inst_valid (inst_valid),
		.inst_hit   (inst_hit)
	);

endmodule

// File: bench/fetch_unit_tb.sv
`include "fetch_params.svh"

module fetch_unit_tb;

	localparam int CLK_HALF       = 10;
	localparam int TEST_CYCLES    = 400; // rough length of all tests.
	localparam int TIMEOUT_CYCLES = 5 * TEST_CYCLES;
	localparam logic [5:0] REPL_SET = 6'd37; // set used for eviction.

	logic             clk = 1'b0;
	logic             rst;
	logic             stall;
	logic             redirect;
	fetch_pkg::addr_t redirect_pc;
	fetch_pkg::addr_t mem_addr;
	fetch_pkg::line_t mem_line;
	fetch_pkg::inst_t inst;
	fetch_pkg::addr_t inst_pc;
	logic             inst_valid;
	logic             inst_hit;

	int          errors  = 0;
	int          outputs = 0;
	int          cycles  = 0;
	logic [31:0] lfsr    = 32'hd489_fa3c;

	// reference cache state.
	fetch_pkg::tag_t         model_tag [`ICACHE_WAYS][`ICACHE_SETS];
	logic [`ICACHE_SETS-1:0] model_vld [`ICACHE_WAYS];
	fetch_pkg::way_t         model_ptr;

	always #CLK_HALF clk = ~clk;

	always @(posedge clk) cycles <= cycles + 1;

	fetch_unit u_fetch_unit (
		.clk         (clk),
		.rst         (rst),
		.stall       (stall),
		.redirect    (redirect),
		.redirect_pc (redirect_pc),
		.mem_addr    (mem_addr),
		.mem_line    (mem_line),
		.inst        (inst),
		.inst_pc     (inst_pc),
		.inst_valid  (inst_valid),
		.inst_hit    (inst_hit)
	);

	// ***********************************************************************
	// memory model and helpers.
	// ***********************************************************************

	function automatic fetch_pkg::inst_t mem_word(input fetch_pkg::addr_t a);
		return a[31:0] ^ 32'h9e37_79b9;
	endfunction

	always_comb begin
		for (int k = 0; k < 4; k++) begin
			mem_line[32*k +: 32] = mem_word(mem_addr + 64'(4 * k)); // word 0 low.
		end
	end

	// fibonacci lfsr with taps 32 22 2 1.
	function automatic logic [63:0] rand_bits(input int n);
		logic [63:0] v;
		logic        fb;
		v = '0;
		for (int i = 0; i < n; i++) begin
			fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
			lfsr = {lfsr[30:0], fb};
			v    = {v[62:0], fb};
		end
		return v;
	endfunction

	// predicts the hit and fills the pointed way on a miss.
	task automatic model_access(input fetch_pkg::addr_t a, output logic hit);
		fetch_pkg::index_t idx;
		fetch_pkg::tag_t   tg;
		idx = a[9:4];
		tg  = a[63:10];
		hit = 1'b0;
		for (int w = 0; w < `ICACHE_WAYS; w++) begin
			if (model_vld[w][idx] && model_tag[w][idx] == tg) begin
				hit = 1'b1;
			end
		end
		if (!hit) begin
			for (int w = 0; w < `ICACHE_WAYS; w++) begin
				if (model_ptr[w]) begin
					model_tag[w][idx] = tg;
					model_vld[w][idx] = 1'b1;
				end
			end
			model_ptr = {model_ptr[`ICACHE_WAYS-2:0], model_ptr[`ICACHE_WAYS-1]};
		end
	endtask

	task automatic report_mismatch(input string name, input logic [63:0] exp,
		input logic [63:0] got);
		$display("FAILED %s: expected %h, got %h", name, exp, got);
		errors++;
	endtask

	task automatic check_no_output();
		if (inst_valid !== 1'b0) report_mismatch("inst_valid", 64'(0), 64'(inst_valid));
		if (inst_hit !== 1'b0) report_mismatch("inst_hit", 64'(0), 64'(inst_hit));
	endtask

	// one new output against memory and the cache model.
	task automatic check_out(input fetch_pkg::addr_t a);
		logic exp_hit;
		model_access(a, exp_hit);
		outputs++;
		if (inst_valid !== 1'b1) report_mismatch("inst_valid", 64'(1), 64'(inst_valid));
		if (inst_pc !== a) report_mismatch("inst_pc", a, inst_pc);
		if (inst !== mem_word(a)) report_mismatch("inst", 64'(mem_word(a)), 64'(inst));
		if (inst_hit !== exp_hit) report_mismatch("inst_hit", 64'(exp_hit), 64'(inst_hit));
	endtask

	// redirect from a stalled pipe, then let the target through once.
	task automatic jump_to(input fetch_pkg::addr_t target, input logic in_stall);
		@(posedge clk);
		redirect    <= 1'b1;
		redirect_pc <= target;
		stall       <= in_stall;
		@(posedge clk);
		redirect <= 1'b0;
		@(negedge clk);
		check_no_output(); // dropped lookup.
		// lookup of the target goes out line aligned.
		if (mem_addr !== {target[63:4], 4'b0000}) begin
			report_mismatch("mem_addr", {target[63:4], 4'b0000}, mem_addr);
		end
		if (in_stall) begin
			@(posedge clk);
			stall <= 1'b0;
		end
		@(posedge clk);
		stall <= 1'b1;
		@(negedge clk);
		check_out(target);
	endtask

	// ***********************************************************************
	// directed tests.
	// ***********************************************************************

	task automatic reset_test();
		for (int w = 0; w < `ICACHE_WAYS; w++) begin
			model_vld[w] = '0;
		end
		model_ptr = fetch_pkg::way_t'(1);
		for (int i = 0; i < 10; i++) begin
			@(posedge clk);
			if (i == 9) rst <= 1'b0;
			@(negedge clk);
			check_no_output();
		end
		@(posedge clk);
		@(negedge clk);
		check_no_output(); // first edge out of reset.
		@(posedge clk);
		@(negedge clk);
		if (inst_pc !== `FETCH_RESET_PC) report_mismatch("inst_pc", `FETCH_RESET_PC, inst_pc);
	endtask

	task automatic sequential_test();
		fetch_pkg::addr_t a;
		for (int i = 0; i < 16; i++) begin
			a = `FETCH_RESET_PC + 64'(4 * i);
			if (i > 0) begin
				@(posedge clk);
				if (i == 15) stall <= 1'b1; // hold the lookup after the last word.
				@(negedge clk);
			end
			if (inst_hit !== ((i % 4) != 0)) begin
				report_mismatch("inst_hit", 64'((i % 4) != 0), 64'(inst_hit));
			end
			check_out(a);
		end
	endtask

	task automatic stall_test();
		fetch_pkg::inst_t held_inst;
		fetch_pkg::addr_t held_pc;
		held_pc   = `FETCH_RESET_PC + 64'd60; // last sequential word.
		held_inst = mem_word(held_pc);
		repeat (6) begin
			@(posedge clk);
			@(negedge clk);
			if (inst !== held_inst) report_mismatch("inst", 64'(held_inst), 64'(inst));
			if (inst_pc !== held_pc) report_mismatch("inst_pc", held_pc, inst_pc);
			if (inst_valid !== 1'b1) report_mismatch("inst_valid", 64'(1), 64'(inst_valid));
		end
		@(posedge clk);
		stall <= 1'b0;
		@(posedge clk);
		stall <= 1'b1;
		@(negedge clk);
		check_out(held_pc + 64'd4);
	endtask

	task automatic redirect_test();
		jump_to(64'h8000_1238, 1'b0);
		jump_to(64'h9000_04a4, 1'b1); // redirect while stalled.
		jump_to(`FETCH_RESET_PC + 64'd8, 1'b0); // line still cached.
	endtask

	task automatic replacement_test();
		fetch_pkg::addr_t lines [5];
		fetch_pkg::tag_t  tg;
		logic [1:0]       word;
		logic             dup;
		for (int n = 0; n < 5; n++) begin
			do begin
				tg  = fetch_pkg::tag_t'(rand_bits(54));
				dup = 1'b0;
				for (int m = 0; m < n; m++) begin
					if (lines[m][63:10] == tg) dup = 1'b1;
				end
			end while (dup);
			word     = 2'(rand_bits(2));
			lines[n] = {tg, REPL_SET, word, 2'b00};
		end
		for (int n = 0; n < 5; n++) begin
			jump_to(lines[n], 1'b0); // fifth line evicts.
		end
		for (int n = 4; n >= 0; n--) begin
			jump_to(lines[n], 1'b0); // only the evicted first line misses.
		end
	endtask

	// ***********************************************************************
	// run control.
	// ***********************************************************************

	initial begin
		rst         <= 1'b1;
		stall       <= 1'b0;
		redirect    <= 1'b0;
		redirect_pc <= '0;
		reset_test();
		sequential_test();
		stall_test();
		redirect_test();
		replacement_test();
		$display("%0d errors in %0d outputs checked", errors, outputs);
		if (errors == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

	initial begin
		wait (cycles >= TIMEOUT_CYCLES);
		$display("run stopped by timeout after %0d cycles", cycles);
		$display("%0d errors in %0d outputs checked", errors, outputs);
		$display("Result: FAILED");
		$finish;
	end

endmodule

// File: fetch_unit.f
+incdir+source
source/fetch_pkg.sv
source/fetch_stage_if.sv
source/pc_gen.sv
source/icache_tag_stage.sv
source/way_sram.sv
source/icache_data_stage.sv
source/fetch_unit.sv
bench/fetch_unit_tb.sv

// File: run.sh
#!/bin/sh
# build and run the fetch unit testbench with verilator.
set -e

cd "$(dirname "$0")"

verilator --binary --timing \
	--top-module fetch_unit_tb \
	-f fetch_unit.f \
	-o fetch_unit_sim

out=$(./obj_dir/fetch_unit_sim)
echo "$out"
echo "$out" | grep -qx "Result: PASSED"
